//--- video_pkg.sv
// package with register numbers, display word union, pixel and address types
package video_pkg;

    typedef logic [15:0] addr_t;        // video RAM word address
    typedef logic [11:0] tile_addr_t;   // tile memory word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [10:0] count_t;       // raster counter
    typedef logic [4:0]  reg_num_t;

    // index 7 holds pixel 0, the first one shifted out
    typedef color_t [7:0] pixel_group_t;

    localparam reg_num_t REG_VID_CTRL  = 5'h00;    // wr pulses intr, rd gives intr status
    localparam reg_num_t REG_SCANLINE  = 5'h01;    // read only raster status
    localparam reg_num_t REG_GFX_CTRL  = 5'h02;    // colorbase, blank, bitmap
    localparam reg_num_t REG_TILE_CTRL = 5'h03;    // tile bank
    localparam reg_num_t REG_DISP_ADDR = 5'h04;
    localparam reg_num_t REG_LINE_LEN  = 5'h05;

    // one display word, seen as a text cell or as four bitmap pixels
    typedef union packed {
        struct packed {
            logic [3:0] bg;         // background colour
            logic [3:0] fg;         // foreground colour
            logic [7:0] glyph;      // glyph index into tile memory
        } tile;
        logic [3:0][3:0] pix;       // pix[3] is the leftmost pixel
    } display_word_u;

    typedef struct packed {
        color_t     colorbase;      // upper colour bits for all pixels
        logic       blank;          // playfield off, no memory fetch
        logic       bitmap;         // 4 bpp bitmap, else 1 bpp text
        logic [1:0] tile_bank;
        addr_t      disp_addr;      // first line start of the frame
        addr_t      line_len;       // words added per line (text row)
    } gfx_cfg_t;

endpackage

//--- video_timing_if.sv
// interface carrying raster position and timing events
interface video_timing_if;
    import video_pkg::*;

    count_t h_count;
    count_t v_count;
    logic   h_visible;
    logic   v_visible;
    logic   line_end;       // last pixel of any line
    logic   frame_end;      // last pixel of the frame
    logic   vblank_start;   // last visible pixel of last visible line
    logic   fetch_start;    // 16 pixels before first visible pixel
    logic   scan_start;     // 2 pixels before first visible pixel

    modport gen (
        output h_count, v_count, h_visible, v_visible,
        output line_end, frame_end, vblank_start, fetch_start, scan_start
    );

    modport sink (
        input h_count, v_count, h_visible, v_visible,
        input line_end, frame_end, vblank_start, fetch_start, scan_start
    );

endinterface

//--- video_regs.sv
// configuration register file with readback and interrupt pulses
module video_regs #(
    parameter int H_VISIBLE = 640
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  video_pkg::reg_num_t reg_num_i,
    input  logic [15:0]         reg_data_i,
    input  logic [3:0]          intr_status_i,
    video_timing_if.sink        timing,
    output logic [15:0]         reg_data_o,
    output logic [3:0]          intr_o,
    output video_pkg::gfx_cfg_t cfg_o
);
    import video_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_o            <= 4'b0;
            cfg_o.colorbase   <= 8'h00;
            cfg_o.blank       <= 1'b0;
            cfg_o.bitmap      <= 1'b0;
            cfg_o.tile_bank   <= 2'b00;
            cfg_o.disp_addr   <= 16'h0000;
            cfg_o.line_len    <= addr_t'(H_VISIBLE / 8);   // one text row of cells
        end else begin
            intr_o <= 4'b0;                                 // pulses last one cycle
            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_VID_CTRL: begin
                        intr_o <= reg_data_i[3:0];
                    end
                    REG_GFX_CTRL: begin
                        cfg_o.colorbase <= reg_data_i[15:8];
                        cfg_o.blank     <= reg_data_i[7];
                        cfg_o.bitmap    <= reg_data_i[6];
                    end
                    REG_TILE_CTRL: begin
                        cfg_o.tile_bank <= reg_data_i[11:10];
                    end
                    REG_DISP_ADDR: begin
                        cfg_o.disp_addr <= reg_data_i;
                    end
                    REG_LINE_LEN: begin
                        cfg_o.line_len  <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
            if (timing.vblank_start) begin
                intr_o[3] <= 1'b1;                          // once per frame
            end
        end
    end

    // readback is registered, valid one cycle after reg_num_i
    always_ff @(posedge clk) begin
        case (reg_num_i)
            REG_VID_CTRL:  reg_data_o <= {12'h000, intr_status_i};
            REG_SCANLINE:  reg_data_o <= {~timing.v_visible, ~timing.h_visible, 3'b000,
                                          timing.v_count};
            REG_GFX_CTRL:  reg_data_o <= {cfg_o.colorbase, cfg_o.blank, cfg_o.bitmap, 6'b0};
            REG_TILE_CTRL: reg_data_o <= {4'b0, cfg_o.tile_bank, 10'b0};
            REG_DISP_ADDR: reg_data_o <= cfg_o.disp_addr;
            REG_LINE_LEN:  reg_data_o <= cfg_o.line_len;
            default:       reg_data_o <= 16'h0000;
        endcase
    end

endmodule

//--- video_timing.sv
// raster state machines, sync outputs, display enable and fetch window events
module video_timing #(
    parameter int H_VISIBLE  = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,
    parameter bit V_SYNC_POL = 1'b0
) (
    input  logic        clk,
    input  logic        reset_i,
    video_timing_if.gen timing,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);
    import video_pkg::*;

    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;    // offscreen pixels on the left
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    typedef enum logic [1:0] {
        ST_PRE_SYNC  = 2'b00,
        ST_SYNC      = 2'b01,
        ST_POST_SYNC = 2'b10,
        ST_VISIBLE   = 2'b11
    } raster_state_t;

    raster_state_t h_state;
    raster_state_t v_state;
    count_t        h_last;      // h_count where the current h state ends
    count_t        v_last;      // v_count where the current v state ends
    logic          line_end;

    // horizontal: offscreen first, visible last
    always_comb begin
        case (h_state)
            ST_PRE_SYNC:  h_last = count_t'(H_FRONT - 1);
            ST_SYNC:      h_last = count_t'(H_FRONT + H_SYNC - 1);
            ST_POST_SYNC: h_last = count_t'(H_OFF - 1);
            default:      h_last = count_t'(H_TOTAL - 1);
        endcase
    end

    // vertical: visible lines first, blanking at the bottom
    always_comb begin
        case (v_state)
            ST_VISIBLE:   v_last = count_t'(V_VISIBLE - 1);
            ST_PRE_SYNC:  v_last = count_t'(V_VISIBLE + V_FRONT - 1);
            ST_SYNC:      v_last = count_t'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:      v_last = count_t'(V_TOTAL - 1);
        endcase
    end

    assign line_end           = (timing.h_count == count_t'(H_TOTAL - 1));
    assign timing.line_end    = line_end;
    assign timing.frame_end   = line_end && (timing.v_count == count_t'(V_TOTAL - 1));
    assign timing.h_visible   = (h_state == ST_VISIBLE);
    assign timing.v_visible   = (v_state == ST_VISIBLE);
    assign timing.vblank_start = line_end && (timing.v_count == count_t'(V_VISIBLE - 1));
    assign timing.fetch_start = timing.v_visible && (timing.h_count == count_t'(H_OFF - 16));
    assign timing.scan_start  = timing.v_visible && (timing.h_count == count_t'(H_OFF - 2));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state        <= ST_PRE_SYNC;
            v_state        <= ST_VISIBLE;
            timing.h_count <= '0;
            timing.v_count <= '0;
            hsync_o        <= ~H_SYNC_POL;
            vsync_o        <= ~V_SYNC_POL;
            dv_de_o        <= 1'b0;
        end else begin
            timing.h_count <= line_end ? '0 : timing.h_count + 1'b1;
            if (timing.h_count == h_last) begin
                h_state <= raster_state_t'(h_state + 2'd1);
            end
            if (line_end) begin
                timing.v_count <= timing.frame_end ? '0 : timing.v_count + 1'b1;
                if (timing.v_count == v_last) begin
                    v_state <= raster_state_t'(v_state + 2'd1);
                end
            end
            hsync_o <= (h_state == ST_SYNC) ? H_SYNC_POL : ~H_SYNC_POL;
            vsync_o <= (v_state == ST_SYNC) ? V_SYNC_POL : ~V_SYNC_POL;
            dv_de_o <= timing.h_visible && timing.v_visible;
        end
    end

endmodule

//--- playfield_fetch.sv
// display memory fetch sequencer, line addressing, tile lookup and pixel expansion
module playfield_fetch #(
    parameter int H_VISIBLE = 640
) (
    input  logic                    clk,
    input  logic                    reset_i,
    video_timing_if.sink            timing,
    input  video_pkg::gfx_cfg_t     cfg_i,
    input  logic [15:0]             vram_data_i,
    input  logic [15:0]             tilemem_data_i,
    input  logic                    credit_return_i,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    output logic                    tilemem_sel_o,
    output video_pkg::tile_addr_t   tilemem_addr_o,
    output logic                    group_valid_o,
    output video_pkg::pixel_group_t group_o
);
    import video_pkg::*;

    localparam count_t GROUPS = count_t'(H_VISIBLE / 8);   // 8 pixel groups per line

    logic          fetch_active;
    logic [2:0]    cycle;           // step of the 8 cycle fetch loop
    logic          credit;          // one credit towards the scanout
    count_t        groups_left;
    addr_t         line_start;
    addr_t         disp_addr;       // next display word to read
    logic [2:0]    tile_y;          // row inside the 8x8 glyph
    display_word_u cur_word;        // display word straight from vram
    display_word_u word0;           // first display word (text cell or 4 pixels)
    display_word_u word1;           // tile word or second display word
    logic [7:0]    tile_byte;
    pixel_group_t  next_group;
    logic          run;
    logic          issue_disp;
    logic          issue_tile;
    logic          deliver;

    assign cur_word   = vram_data_i;
    assign run        = fetch_active && !cfg_i.blank;
    assign issue_disp = run && ((cycle == 3'd0) || (cycle == 3'd2 && cfg_i.bitmap));
    assign issue_tile = run && (cycle == 3'd2) && !cfg_i.bitmap;
    assign deliver    = run && (cycle == 3'd5) && credit;
    assign tile_byte  = tile_y[0] ? word1[7:0] : word1[15:8];  // even rows in high byte

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (cfg_i.bitmap) begin
                next_group[7-i] = {cfg_i.colorbase[7:4],
                                   (i < 4) ? word0.pix[3-i] : word1.pix[7-i]};
            end else begin
                next_group[7-i] = {cfg_i.colorbase[7:4],
                                   tile_byte[7-i] ? word0.tile.fg : word0.tile.bg};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_active  <= 1'b0;
            cycle         <= 3'd0;
            credit        <= 1'b1;
            groups_left   <= '0;
            line_start    <= '0;
            disp_addr     <= '0;
            tile_y        <= 3'd0;
            vram_sel_o    <= 1'b0;
            tilemem_sel_o <= 1'b0;
            group_valid_o <= 1'b0;
        end else begin
            vram_sel_o    <= issue_disp;
            tilemem_sel_o <= issue_tile;
            if (issue_disp) begin
                disp_addr <= disp_addr + 1'b1;
            end
            if (run && (cycle != 3'd5 || credit)) begin
                cycle <= cycle + 1'b1;              // waits at step 5 without credit
            end
            if (credit_return_i) begin
                credit        <= 1'b1;
                group_valid_o <= 1'b0;
            end
            if (deliver) begin
                credit        <= 1'b0;
                group_valid_o <= 1'b1;
                groups_left   <= groups_left - 1'b1;
                if (groups_left == count_t'(1)) begin
                    fetch_active <= 1'b0;           // line complete
                end
            end
            if (timing.fetch_start) begin
                fetch_active  <= !cfg_i.blank;
                cycle         <= 3'd0;
                credit        <= 1'b1;
                group_valid_o <= 1'b0;
                groups_left   <= GROUPS;
                disp_addr     <= line_start;
            end
            if (timing.frame_end) begin
                line_start <= cfg_i.disp_addr;
                tile_y     <= 3'd0;
            end else if (timing.line_end && timing.v_visible) begin
                tile_y <= tile_y + 1'b1;
                if (cfg_i.bitmap || tile_y == 3'd7) begin
                    line_start <= line_start + cfg_i.line_len;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_disp) begin
            vram_addr_o <= disp_addr;
        end
        if (run && cycle == 3'd2) begin
            word0          <= vram_data_i;
            tilemem_addr_o <= {cfg_i.tile_bank, cur_word.tile.glyph, tile_y[2:1]};
        end
        if (run && cycle == 3'd4) begin
            word1 <= cfg_i.bitmap ? vram_data_i : tilemem_data_i;
        end
        if (deliver) begin
            group_o <= next_group;
        end
    end

endmodule

//--- pixel_scanout.sv
// eight pixel shifter with credit return and colour index output
module pixel_scanout (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    scan_start_i,
    input  logic                    line_end_i,
    input  video_pkg::color_t       colorbase_i,
    input  logic                    group_valid_i,
    input  video_pkg::pixel_group_t group_i,
    output logic                    credit_return_o,
    output video_pkg::color_t       color_index_o
);
    import video_pkg::*;

    logic         start_q;      // load one cycle after scan_start
    logic         active;       // shifting out a line
    logic [2:0]   phase;        // pixel within the current group
    logic         load;
    pixel_group_t shift_q;

    assign load = start_q || (active && phase == 3'd7 && !line_end_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_q         <= 1'b0;
            active          <= 1'b0;
            phase           <= 3'd0;
            credit_return_o <= 1'b0;
        end else begin
            start_q         <= scan_start_i;
            credit_return_o <= load && group_valid_i;
            if (load) begin
                active <= 1'b1;
                phase  <= 3'd0;
            end else if (active) begin
                phase  <= phase + 1'b1;
            end
            if (line_end_i) begin
                active <= 1'b0;
            end
        end
    end

    // an empty slot shows colorbase
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= group_valid_i ? group_i : {8{colorbase_i}};
        end else begin
            shift_q <= {shift_q[6:0], colorbase_i};
        end
        color_index_o <= active ? shift_q[7] : colorbase_i;
    end

endmodule

//--- video_gen.sv
// top level of the playfield video generator
module video_gen #(
    parameter int H_VISIBLE  = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,
    parameter bit V_SYNC_POL = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  reg_wr_i,
    input  video_pkg::reg_num_t   reg_num_i,
    input  logic [15:0]           reg_data_i,
    output logic [15:0]           reg_data_o,
    input  logic [3:0]            intr_status_i,
    output logic [3:0]            intr_o,
    output logic                  vram_sel_o,
    output video_pkg::addr_t      vram_addr_o,
    input  logic [15:0]           vram_data_i,
    output logic                  tilemem_sel_o,
    output video_pkg::tile_addr_t tilemem_addr_o,
    input  logic [15:0]           tilemem_data_i,
    output video_pkg::color_t     color_index_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_de_o
);
    import video_pkg::*;

    gfx_cfg_t     cfg;
    logic         group_valid;
    pixel_group_t group;
    logic         credit_return;

    video_timing_if timing ();

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) u_timing (
        .clk(clk), .reset_i(reset_i), .timing(timing.gen),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    video_regs #(.H_VISIBLE(H_VISIBLE)) u_regs (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .intr_status_i(intr_status_i), .timing(timing.sink),
        .reg_data_o(reg_data_o), .intr_o(intr_o), .cfg_o(cfg)
    );

    playfield_fetch #(.H_VISIBLE(H_VISIBLE)) u_fetch (
        .clk(clk), .reset_i(reset_i), .timing(timing.sink), .cfg_i(cfg),
        .vram_data_i(vram_data_i), .tilemem_data_i(tilemem_data_i),
        .credit_return_i(credit_return),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .tilemem_sel_o(tilemem_sel_o), .tilemem_addr_o(tilemem_addr_o),
        .group_valid_o(group_valid), .group_o(group)
    );

    pixel_scanout u_scanout (
        .clk(clk), .reset_i(reset_i), .scan_start_i(timing.scan_start),
        .line_end_i(timing.line_end), .colorbase_i(cfg.colorbase),
        .group_valid_i(group_valid), .group_i(group),
        .credit_return_o(credit_return), .color_index_o(color_index_o)
    );

endmodule

//--- tb_video_mem.sv
// video RAM and tile memory models with two-cycle read latency
module tb_video_mem (
    input  logic                  clk,
    input  logic                  vram_sel_i,
    input  video_pkg::addr_t      vram_addr_i,
    output logic [15:0]           vram_data_o,
    input  logic                  tilemem_sel_i,
    input  video_pkg::tile_addr_t tilemem_addr_i,
    output logic [15:0]           tilemem_data_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    logic [15:0] vram [0:65535];    // filled by the testbench top
    logic [15:0] tmem [0:4095];

    logic       vram_q;
    addr_t      vram_addr_q;
    logic       tmem_q;
    tile_addr_t tmem_addr_q;

    // the DUT registers sel/addr on one edge, the model takes them on the next
    always_ff @(posedge clk) begin
        vram_q      <= vram_sel_i;
        vram_addr_q <= vram_addr_i;
        tmem_q      <= tilemem_sel_i;
        tmem_addr_q <= tilemem_addr_i;
    end

    // data is then stable up to the second edge after the request
    assign vram_data_o    = vram_q ? vram[vram_addr_q] : 16'h0000;
    assign tilemem_data_o = tmem_q ? tmem[tmem_addr_q] : 16'h0000;

endmodule

//--- tb_video_gen.sv
// testbench top with clock, stimulus, assertions, watchdog and report
module tb_video_gen;
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    localparam int H_VISIBLE = 64;
    localparam int H_SYNC    = 8;
    localparam int V_VISIBLE = 16;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int H_TOTAL   = H_VISIBLE + 8 + H_SYNC + 24;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + 2;
    localparam int FRAME     = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS = (16 + 6 * FRAME) * 8;
    localparam bit SYNC_POL  = 1'b0;

    logic clk;
    logic reset_i;
    logic reg_wr_i;
    reg_num_t reg_num_i;
    logic [15:0] reg_data_i;
    logic [15:0] reg_data_o;
    logic [3:0] intr_status_i;
    logic [3:0] intr_o;
    logic vram_sel_o;
    addr_t vram_addr_o;
    logic [15:0] vram_data_i;
    logic tilemem_sel_o;
    tile_addr_t tilemem_addr_o;
    logic [15:0] tilemem_data_i;
    color_t color_index_o;
    logic hsync_o;
    logic vsync_o;
    logic dv_de_o;

    int errors;
    int px_checked;
    logic check_px;             // compare displayed pixels
    logic check_blank;
    logic rd_check;
    logic [15:0] rd_expect;
    logic pulse_check;
    logic [3:0] pulse_expect;

    // configuration as last written for the expected pixels
    color_t sh_cb;
    logic sh_bitmap;
    logic [1:0] sh_bank;
    addr_t sh_disp;
    addr_t sh_len;

    logic hs_act, hs_prev, hs_rise, hs_seen;
    logic vs_act, vs_prev, vs_rise, vs_seen;
    logic de_prev;
    int h_period, v_period, hs_len, de_len, vs_lines, intr_cnt;
    int line_cnt, px_cnt, cur_line, cur_px;
    logic px_window;
    color_t exp_px;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(8), .H_SYNC(H_SYNC), .H_BACK(24),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(2),
        .H_SYNC_POL(SYNC_POL), .V_SYNC_POL(SYNC_POL)
    ) uut (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i), .intr_o(intr_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .tilemem_sel_o(tilemem_sel_o), .tilemem_addr_o(tilemem_addr_o),
        .tilemem_data_i(tilemem_data_i), .color_index_o(color_index_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    tb_video_mem mem (
        .clk(clk), .vram_sel_i(vram_sel_o), .vram_addr_i(vram_addr_o),
        .vram_data_o(vram_data_i), .tilemem_sel_i(tilemem_sel_o),
        .tilemem_addr_i(tilemem_addr_o), .tilemem_data_o(tilemem_data_i)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // pixel px of visible line y by the addressing and expansion rules
    function automatic color_t expected_pixel(input int y, input int px);
        addr_t a;
        logic [15:0] w;
        logic [15:0] t;
        logic [2:0] row;
        logic [7:0] b;
        if (sh_bitmap) begin
            a = sh_disp + addr_t'(y) * sh_len + addr_t'(px / 4);
            w = mem.vram[a];
            return {sh_cb[7:4], w[(15 - 4 * (px % 4)) -: 4]};
        end
        a = sh_disp + addr_t'(y / 8) * sh_len + addr_t'(px / 8);
        w = mem.vram[a];
        row = 3'(y % 8);
        t = mem.tmem[{sh_bank, w[7:0], row[2:1]}];
        b = row[0] ? t[7:0] : t[15:8];  // even rows in the high byte
        return {sh_cb[7:4], b[7 - (px % 8)] ? w[11:8] : w[15:12]};
    endfunction

    assign hs_act  = (hsync_o == SYNC_POL);
    assign vs_act  = (vsync_o == SYNC_POL);
    assign hs_rise = hs_act && !hs_prev;
    assign vs_rise = vs_act && !vs_prev;
    assign cur_px   = de_prev ? px_cnt : 0;             // first de cycle is pixel 0
    assign cur_line = de_prev ? line_cnt : line_cnt + 1;
    assign px_window = check_px && dv_de_o && cur_line >= 0 && cur_line < V_VISIBLE
                       && cur_px < H_VISIBLE;

    always_comb begin
        exp_px = 8'h00;
        if (cur_line >= 0 && cur_line < V_VISIBLE && cur_px < H_VISIBLE) begin
            exp_px = expected_pixel(cur_line, cur_px);
        end
    end

    // raster measurements taken from the DUT outputs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            de_prev <= 1'b0;
            hs_seen <= 1'b0;
            vs_seen <= 1'b0;
            h_period <= 0;
            v_period <= 0;
            hs_len <= 0;
            de_len <= 0;
            vs_lines <= 0;
            intr_cnt <= 0;
            line_cnt <= -1;
            px_cnt <= 0;
            px_checked <= 0;
        end else begin
            hs_prev <= hs_act;
            vs_prev <= vs_act;
            de_prev <= dv_de_o;
            h_period <= hs_rise ? 1 : h_period + 1;
            v_period <= vs_rise ? 1 : v_period + 1;
            hs_seen <= hs_seen || hs_rise;
            vs_seen <= vs_seen || vs_rise;
            hs_len <= hs_act ? hs_len + 1 : 0;
            de_len <= dv_de_o ? de_len + 1 : 0;
            vs_lines <= vs_act ? vs_lines + int'(hs_rise) : 0;
            intr_cnt <= vs_rise ? int'(intr_o[3]) : intr_cnt + int'(intr_o[3]);
            if (vs_rise) begin
                line_cnt <= -1;                         // next displayed line is line 0
            end else if (dv_de_o) begin
                line_cnt <= cur_line;
            end
            if (dv_de_o) begin
                px_cnt <= cur_px + 1;
            end
            if (px_window) begin
                px_checked <= px_checked + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (hs_rise && hs_seen) |-> h_period == H_TOTAL)
    else begin
        errors++;
        $display("CHECK FAILED hsync_o period: expected %h actual %h", H_TOTAL,
                 $sampled(h_period));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (hs_prev && !hs_act) |-> hs_len == H_SYNC)
    else begin
        errors++;
        $display("CHECK FAILED hsync_o width: expected %h actual %h", H_SYNC, $sampled(hs_len));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (de_prev && !dv_de_o) |-> de_len == H_VISIBLE)
    else begin
        errors++;
        $display("CHECK FAILED dv_de_o width: expected %h actual %h", H_VISIBLE,
                 $sampled(de_len));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (vs_prev && !vs_act) |-> vs_lines == V_SYNC)
    else begin
        errors++;
        $display("CHECK FAILED vsync_o lines: expected %h actual %h", V_SYNC,
                 $sampled(vs_lines));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (vs_rise && vs_seen) |-> v_period == FRAME)
    else begin
        errors++;
        $display("CHECK FAILED vsync_o period: expected %h actual %h", FRAME,
                 $sampled(v_period));
    end

    assert property (@(posedge clk) disable iff (reset_i) vs_rise |-> intr_cnt == 1)
    else begin
        errors++;
        $display("CHECK FAILED intr_o[3] per frame: expected %h actual %h", 1,
                 $sampled(intr_cnt));
    end

    assert property (@(posedge clk) disable iff (reset_i) (intr_o != 4'h0) |=> intr_o == 4'h0)
    else begin
        errors++;
        $display("CHECK FAILED intr_o width: expected %h actual %h", 4'h0,
                 $sampled(intr_o));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        pulse_check |=> intr_o == pulse_expect)
    else begin
        errors++;
        $display("CHECK FAILED intr_o: expected %h actual %h", $sampled(pulse_expect),
                 $sampled(intr_o));
    end

    assert property (@(posedge clk) disable iff (reset_i) rd_check |=> reg_data_o == rd_expect)
    else begin
        errors++;
        $display("CHECK FAILED reg_data_o: expected %h actual %h", $sampled(rd_expect),
                 $sampled(reg_data_o));
    end

    assert property (@(posedge clk) disable iff (reset_i) px_window |-> color_index_o == exp_px)
    else begin
        errors++;
        $display("CHECK FAILED color_index_o line %0d pixel %0d: expected %h actual %h",
                 $sampled(cur_line), $sampled(cur_px), $sampled(exp_px),
                 $sampled(color_index_o));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        check_blank |-> !vram_sel_o && !tilemem_sel_o)
    else begin
        errors++;
        $display("CHECK FAILED vram_sel_o/tilemem_sel_o: expected %h actual %h", 2'b00,
                 {$sampled(vram_sel_o), $sampled(tilemem_sel_o)});
    end

    assert property (@(posedge clk) disable iff (reset_i)
        check_blank |-> color_index_o == sh_cb)
    else begin
        errors++;
        $display("CHECK FAILED color_index_o blank: expected %h actual %h", sh_cb,
                 $sampled(color_index_o));
    end

    task automatic write_reg(input reg_num_t n, input logic [15:0] d);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= n;
        reg_data_i <= d;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
    endtask

    task automatic read_check(input reg_num_t n, input logic [15:0] expect_val);
        reg_num_i <= n;
        rd_check  <= 1'b1;
        rd_expect <= expect_val;
        @(posedge clk);
        rd_check  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_vsync();
        do @(posedge clk); while (!vs_rise);
    endtask

    task automatic set_mode(input color_t cb, input logic bm, input logic [1:0] bank,
                            input addr_t disp, input addr_t len);
        write_reg(REG_GFX_CTRL, {cb, 1'b0, bm, 6'b0});
        write_reg(REG_TILE_CTRL, {4'h0, bank, 10'h000});
        write_reg(REG_DISP_ADDR, disp);
        write_reg(REG_LINE_LEN, len);
        sh_cb     = cb;
        sh_bitmap = bm;
        sh_bank   = bank;
        sh_disp   = disp;
        sh_len    = len;
        repeat (4) @(posedge clk);                      // let the writes settle
    endtask

    initial begin
        logic [31:0] state;
        clk = 1'b0;
        reset_i = 1'b1;
        reg_wr_i = 1'b0;
        reg_num_i = '0;
        reg_data_i = 16'h0000;
        intr_status_i = 4'h9;
        errors = 0;
        check_px = 1'b0;
        check_blank = 1'b0;
        rd_check = 1'b0;
        rd_expect = 16'h0000;
        pulse_check = 1'b0;
        pulse_expect = 4'h0;
        sh_cb = 8'h00;
        sh_bitmap = 1'b0;
        sh_bank = 2'b00;
        sh_disp = '0;
        sh_len = '0;
        state = 32'd7;
        for (int a = 0; a < 65536; a++) begin
            state = xorshift(state);
            mem.vram[a] = state[15:0] ^ 16'(a);
        end
        for (int a = 0; a < 4096; a++) begin
            state = xorshift(state);
            mem.tmem[a] = state[15:0] ^ 16'(a * 3);
        end
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        wait_vsync();
        read_check(REG_SCANLINE, {2'b11, 3'b000, 11'(V_VISIBLE + V_FRONT)});
        read_check(REG_VID_CTRL, 16'h0009);
        write_reg(REG_GFX_CTRL, 16'hA5BF);
        read_check(REG_GFX_CTRL, 16'hA580);
        write_reg(REG_TILE_CTRL, 16'hFFFF);
        read_check(REG_TILE_CTRL, 16'h0C00);
        write_reg(REG_DISP_ADDR, 16'hBEEF);
        read_check(REG_DISP_ADDR, 16'hBEEF);
        write_reg(REG_LINE_LEN, 16'h0123);
        read_check(REG_LINE_LEN, 16'h0123);
        read_check(5'd9, 16'h0000);                     // unmapped number
        pulse_check  <= 1'b1;
        pulse_expect <= 4'h5;
        write_reg(REG_VID_CTRL, 16'h0005);
        pulse_check  <= 1'b0;

        set_mode(8'hA0, 1'b1, 2'b00, 16'h1230, 16'd20);
        check_px <= 1'b1;
        wait_vsync();
        check_px <= 1'b0;

        set_mode(8'h3C, 1'b0, 2'b10, 16'h4321, 16'd11);
        check_px <= 1'b1;
        wait_vsync();
        check_px <= 1'b0;

        write_reg(REG_GFX_CTRL, 16'h7780);              // blank with colorbase 77
        sh_cb = 8'h77;
        repeat (4) @(posedge clk);
        check_blank <= 1'b1;
        wait_vsync();
        check_blank <= 1'b0;
        @(posedge clk);

        $display("errors: %0d, pixels compared: %0d", errors, px_checked);
        if (errors == 0 && px_checked == 2 * V_VISIBLE * H_VISIBLE) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("Something failed");
        $finish;
    end

endmodule

//--- video_gen.f
video_pkg.sv
video_timing_if.sv
video_regs.sv
video_timing.sv
playfield_fetch.sv
pixel_scanout.sv
video_gen.sv
tb_video_mem.sv
tb_video_gen.sv

//--- Makefile
# Verilator build and run of the video generator testbench

VERILATOR ?= verilator
TOP       ?= tb_video_gen
FILELIST  ?= video_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
